// File: hdl/rvPkg.sv
package rvPkg;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opImm    = 7'b0010011,
        opAuipc  = 7'b0010111,
        opStore  = 7'b0100011,
        opReg    = 7'b0110011,
        opLui    = 7'b0110111,
        opBranch = 7'b1100011,
        opJalr   = 7'b1100111,
        opJal    = 7'b1101111
    } opcode_t;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassB
    } aluOp_t;

    typedef enum logic [1:0] {
        loadByte,
        loadHalf,
        loadWord
    } loadSel_t;

    typedef enum logic [1:0] {
        maskByte,
        maskHalf,
        maskWord
    } maskSel_t;

    typedef enum logic [2:0] {
        wbAlu,
        wbPcImm,
        wbImm,
        wbPc4,
        wbMem
    } wbSel_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } rType_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } iType_t;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        opcode_t    opcode;
    } sType_t;

    // branch offset bits are scattered over the word
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        opcode_t    opcode;
    } bType_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        opcode_t     opcode;
    } uType_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        opcode_t    opcode;
    } jType_t;

    typedef union packed {
        rType_t r;
        iType_t i;
        sType_t s;
        bType_t b;
        uType_t u;
        jType_t j;
    } instr_t;

    typedef struct packed {
        aluOp_t   aluOp;
        logic     aluImm;
        logic     aluToPc;
        logic     branch;
        loadSel_t loadSel;
        maskSel_t maskSel;
        logic     uext;
        logic     memWr;
        wbSel_t   wbSel;
        logic     regWr;
        logic     illegal;
    } ctrl_t;

endpackage

// File: hdl/controller.sv
`timescale 1ns/1ps

module controller (
    input  rvPkg::instr_t instr,
    input  logic          zero,
    input  logic          lessThan,
    output rvPkg::ctrl_t  ctrl
);

    rvPkg::ctrl_t dec;
    logic         condBranch;
    logic         taken;

    // funct3 to ALU op for the OP and OP-IMM groups
    function automatic rvPkg::aluOp_t baseOp(input logic [2:0] funct3);
        case (funct3)
            3'b000:  return rvPkg::aluAdd;
            3'b001:  return rvPkg::aluSll;
            3'b010:  return rvPkg::aluSlt;
            3'b011:  return rvPkg::aluSltu;
            3'b100:  return rvPkg::aluXor;
            3'b101:  return rvPkg::aluSrl;
            3'b110:  return rvPkg::aluOr;
            default: return rvPkg::aluAnd;
        endcase
    endfunction

    always_comb begin
        dec = '0;
        dec.aluOp = rvPkg::aluAdd;
        dec.loadSel = rvPkg::loadWord;
        dec.maskSel = rvPkg::maskWord;
        dec.wbSel = rvPkg::wbAlu;
        condBranch = 1'b0;
        case (instr.r.opcode)
            rvPkg::opLui: begin
                dec.aluImm = 1'b1;
                dec.aluOp = rvPkg::aluPassB;
                dec.regWr = 1'b1;
            end
            rvPkg::opAuipc: begin
                dec.wbSel = rvPkg::wbPcImm;
                dec.regWr = 1'b1;
            end
            rvPkg::opJal: begin
                dec.branch = 1'b1;
                dec.wbSel = rvPkg::wbPc4;
                dec.regWr = 1'b1;
            end
            rvPkg::opJalr: begin
                dec.aluImm = 1'b1;
                dec.aluToPc = 1'b1;
                dec.branch = 1'b1;
                dec.wbSel = rvPkg::wbPc4;
                dec.regWr = 1'b1;
                dec.illegal = (instr.i.funct3 != 3'b000);
            end
            rvPkg::opImm: begin
                dec.aluImm = 1'b1;
                dec.regWr = 1'b1;
                dec.aluOp = baseOp(instr.i.funct3);
                if (instr.i.funct3 == 3'b001) begin
                    dec.illegal = (instr.r.funct7 != 7'b0000000);
                end else if (instr.i.funct3 == 3'b101) begin
                    if (instr.r.funct7 == 7'b0100000) begin
                        dec.aluOp = rvPkg::aluSra;
                    end else begin
                        dec.illegal = (instr.r.funct7 != 7'b0000000);
                    end
                end
            end
            rvPkg::opReg: begin
                dec.regWr = 1'b1;
                dec.aluOp = baseOp(instr.r.funct3);
                if (instr.r.funct7 == 7'b0100000 && instr.r.funct3 == 3'b000) begin
                    dec.aluOp = rvPkg::aluSub;
                end else if (instr.r.funct7 == 7'b0100000 && instr.r.funct3 == 3'b101) begin
                    dec.aluOp = rvPkg::aluSra;
                end else begin
                    dec.illegal = (instr.r.funct7 != 7'b0000000);
                end
            end
            rvPkg::opBranch: begin
                condBranch = 1'b1;
                case (instr.b.funct3)
                    3'b000, 3'b001: dec.aluOp = rvPkg::aluSub;
                    3'b100, 3'b101: dec.aluOp = rvPkg::aluSlt;
                    3'b110, 3'b111: dec.aluOp = rvPkg::aluSltu;
                    default:        dec.illegal = 1'b1;
                endcase
            end
            rvPkg::opLoad: begin
                dec.aluImm = 1'b1;
                dec.wbSel = rvPkg::wbMem;
                dec.regWr = 1'b1;
                dec.uext = instr.i.funct3[2];
                case (instr.i.funct3)
                    3'b000, 3'b100: dec.loadSel = rvPkg::loadByte;
                    3'b001, 3'b101: dec.loadSel = rvPkg::loadHalf;
                    3'b010:         dec.loadSel = rvPkg::loadWord;
                    default:        dec.illegal = 1'b1;
                endcase
            end
            rvPkg::opStore: begin
                dec.aluImm = 1'b1;
                dec.memWr = 1'b1;
                case (instr.s.funct3)
                    3'b000:  dec.maskSel = rvPkg::maskByte;
                    3'b001:  dec.maskSel = rvPkg::maskHalf;
                    3'b010:  dec.maskSel = rvPkg::maskWord;
                    default: dec.illegal = 1'b1;
                endcase
            end
            default: begin
                dec.illegal = 1'b1;
            end
        endcase
    end

    // branch condition from the ALU flags
    always_comb begin
        case (instr.b.funct3)
            3'b000:         taken = zero;
            3'b001:         taken = ~zero;
            3'b100, 3'b110: taken = lessThan;
            3'b101, 3'b111: taken = ~lessThan;
            default:        taken = 1'b0;
        endcase
    end

    always_comb begin
        ctrl = dec;
        ctrl.branch = dec.branch | (condBranch & taken);
        // unsupported encodings must not change any state
        if (dec.illegal) begin
            ctrl.regWr = 1'b0;
            ctrl.memWr = 1'b0;
            ctrl.branch = 1'b0;
        end
    end

endmodule

// File: hdl/immDecoder.sv
`timescale 1ns/1ps

module immDecoder (
    input  rvPkg::instr_t instr,
    output logic [31:0]   imm
);

    always_comb begin
        case (instr.i.opcode)
            rvPkg::opImm, rvPkg::opLoad, rvPkg::opJalr: begin
                imm = {{20{instr.i.imm[11]}}, instr.i.imm};
            end
            rvPkg::opStore: begin
                imm = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
            end
            rvPkg::opBranch: begin
                imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                       instr.b.imm10to5, instr.b.imm4to1, 1'b0};
            end
            // upper immediates sit in bits 31:12
            rvPkg::opLui, rvPkg::opAuipc: begin
                imm = {instr.u.imm, 12'b0};
            end
            rvPkg::opJal: begin
                imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19to12,
                       instr.j.imm11, instr.j.imm10to1, 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [31:0]  a,
    input  logic [31:0]  b,
    input  rvPkg::aluOp_t op,
    output logic [31:0]  result,
    output logic         zero
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rvPkg::aluAdd:   result = a + b;
            rvPkg::aluSub:   result = a - b;
            rvPkg::aluSll:   result = a << shamt;
            rvPkg::aluSlt:   result = {31'b0, $signed(a) < $signed(b)};
            rvPkg::aluSltu:  result = {31'b0, a < b};
            rvPkg::aluXor:   result = a ^ b;
            rvPkg::aluSrl:   result = a >> shamt;
            rvPkg::aluSra:   result = $unsigned($signed(a) >>> shamt);
            rvPkg::aluOr:    result = a | b;
            rvPkg::aluAnd:   result = a & b;
            // lui passes the immediate straight through
            rvPkg::aluPassB: result = b;
            default:         result = '0;
        endcase
    end

    assign zero = (result == 32'b0);

endmodule

// File: hdl/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic        clk,
    input  logic [4:0]  rs1Addr,
    input  logic [4:0]  rs2Addr,
    input  logic [4:0]  rdAddr,
    input  logic [31:0] rdData,
    input  logic        rdWr,
    output logic [31:0] rs1Data,
    output logic [31:0] rs2Data
);

    // x0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (rdWr && rdAddr != 5'd0) begin
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Data = (rs1Addr == 5'd0) ? 32'b0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0) ? 32'b0 : regs[rs2Addr];

endmodule

// File: hdl/loadStoreUnit.sv
`timescale 1ns/1ps

module loadStoreUnit (
    input  logic [31:0]  addr,
    input  logic [31:0]  storeData,
    input  logic [31:0]  memReadData,
    input  rvPkg::ctrl_t ctrl,
    output logic [31:0]  memAddr,
    output logic [31:0]  memWriteData,
    output logic [3:0]   wrMask,
    output logic         memWr,
    output logic [31:0]  loadData
);

    logic [4:0]  laneShift;
    logic [3:0]  widthMask;
    logic [31:0] readShifted;

    // byte offset times eight
    assign laneShift = {addr[1:0], 3'b000};

    always_comb begin
        case (ctrl.maskSel)
            rvPkg::maskByte: widthMask = 4'b0001;
            rvPkg::maskHalf: widthMask = 4'b0011;
            default:         widthMask = 4'b1111;
        endcase
    end

    assign memAddr      = addr;
    assign memWriteData = storeData << laneShift;
    assign wrMask       = widthMask << addr[1:0];
    assign memWr        = ctrl.memWr;

    // addressed lane moved down to bit 0
    assign readShifted = memReadData >> laneShift;

    always_comb begin
        case (ctrl.loadSel)
            rvPkg::loadByte: begin
                loadData = {{24{~ctrl.uext & readShifted[7]}}, readShifted[7:0]};
            end
            rvPkg::loadHalf: begin
                loadData = {{16{~ctrl.uext & readShifted[15]}}, readShifted[15:0]};
            end
            default: begin
                loadData = memReadData;
            end
        endcase
    end

endmodule

// File: hdl/cpu.sv
`timescale 1ns/1ps

module cpu (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] instruction,
    input  logic [31:0] memReadData,
    output logic        memWr,
    output logic        except,
    output logic [3:0]  wrMask,
    output logic [31:0] pc,
    output logic [31:0] memAddr,
    output logic [31:0] memWriteData
);

    rvPkg::instr_t instr;
    rvPkg::ctrl_t  ctrl;
    logic [31:0]   imm;
    logic [31:0]   rs1Data;
    logic [31:0]   rs2Data;
    logic [31:0]   aluB;
    logic [31:0]   aluResult;
    logic          aluZero;
    logic [31:0]   loadData;
    logic [31:0]   pcPlus4;
    logic [31:0]   pcImm;
    logic [31:0]   branchTarget;
    logic [31:0]   nextPc;
    logic [31:0]   wbData;
    logic          regWrEn;

    assign instr = instruction;

    controller controllerInst (
        .instr(instr),
        .zero(aluZero),
        .lessThan(aluResult[0]),
        .ctrl(ctrl)
    );

    immDecoder immDecoderInst (
        .instr(instr),
        .imm(imm)
    );

    registerFile registerFileInst (
        .clk(clk),
        .rs1Addr(instr.r.rs1),
        .rs2Addr(instr.r.rs2),
        .rdAddr(instr.r.rd),
        .rdData(wbData),
        .rdWr(regWrEn),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data)
    );

    alu aluInst (
        .a(rs1Data),
        .b(aluB),
        .op(ctrl.aluOp),
        .result(aluResult),
        .zero(aluZero)
    );

    loadStoreUnit loadStoreUnitInst (
        .addr(aluResult),
        .storeData(rs2Data),
        .memReadData(memReadData),
        .ctrl(ctrl),
        .memAddr(memAddr),
        .memWriteData(memWriteData),
        .wrMask(wrMask),
        .memWr(memWr),
        .loadData(loadData)
    );

    assign aluB    = ctrl.aluImm ? imm : rs2Data;
    assign regWrEn = ctrl.regWr & ~ctrl.illegal;
    assign except  = ctrl.illegal;

    assign pcPlus4 = pc + 32'd4;
    assign pcImm   = pc + imm;
    // jalr clears bit 0 of the computed target
    assign branchTarget = ctrl.aluToPc ? {aluResult[31:1], 1'b0} : pcImm;
    assign nextPc       = ctrl.branch ? branchTarget : pcPlus4;

    always_comb begin
        case (ctrl.wbSel)
            rvPkg::wbPcImm: wbData = pcImm;
            rvPkg::wbImm:   wbData = imm;
            rvPkg::wbPc4:   wbData = pcPlus4;
            rvPkg::wbMem:   wbData = loadData;
            default:        wbData = aluResult;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= 32'b0;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

// File: bench/cpuTb_assert.sv
`timescale 1ns/1ps

module cpuTb_assert (
    input logic        clk,
    input logic        reset,
    input logic [31:0] pc,
    input logic        memWr,
    input logic        except,
    input logic [3:0]  wrMask
);

    // read by the testbench at the end of the run
    int failCount = 0;

    pcAfterReset: assert property (@(posedge clk) reset |=> pc == 32'd0)
        else begin
            $error("pc is not zero in the cycle after reset");
            failCount++;
        end

    pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else begin
            $error("pc is not word aligned");
            failCount++;
        end

    // byte, halfword and word masks at every offset
    maskLegal: assert property (@(posedge clk) disable iff (reset)
        memWr |-> wrMask inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                 4'b0011, 4'b0110, 4'b1100, 4'b1111})
        else begin
            $error("write mask is not a legal shifted mask");
            failCount++;
        end

    exceptNoWrite: assert property (@(posedge clk) disable iff (reset) !(except && memWr))
        else begin
            $error("memory write during an unsupported instruction");
            failCount++;
        end

endmodule

bind cpu cpuTb_assert cpuChecks (.*);

// File: bench/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;

    localparam logic [31:0] nopWord = 32'h00000013;

    logic        clk;
    logic        reset;
    logic [31:0] instruction;
    logic [31:0] memReadData;
    logic        memWr;
    logic        except;
    logic [3:0]  wrMask;
    logic [31:0] pc;
    logic [31:0] memAddr;
    logic [31:0] memWriteData;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] lfsrState;
    int          progLen;
    // pc of every executed instruction in order
    int          trace [$];
    logic [31:0] storeData [int];
    logic [31:0] storeAddr [int];
    logic [3:0]  storeMask [int];
    bit          illegalAt [int];

    cpu i_cpu (
        .clk(clk),
        .reset(reset),
        .instruction(instruction),
        .memReadData(memReadData),
        .memWr(memWr),
        .except(except),
        .wrMask(wrMask),
        .pc(pc),
        .memAddr(memAddr),
        .memWriteData(memWriteData)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // instruction memory reads nop while in reset
    always_comb begin
        if (reset) begin
            instruction = nopWord;
        end else begin
            instruction = imem[pc[9:2]];
        end
    end

    assign memReadData = dmem[memAddr[9:2]];

    always @(posedge clk) begin
        if (memWr) begin
            for (int k = 0; k < 4; k++) begin
                if (wrMask[k]) begin
                    dmem[memAddr[9:2]][8*k +: 8] <= memWriteData[8*k +: 8];
                end
            end
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic nextBit();
        logic fb;
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] w;
        w = '0;
        for (int k = 0; k < n; k++) begin
            w[k] = nextBit();
        end
        return w;
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] aluRef(input logic [2:0] f3, input bit alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $unsigned($signed(a) >>> b[4:0]);
                end
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] loadRef(input logic [31:0] word, input int off,
                                            input logic [2:0] f3);
        logic [31:0] s;
        s = word >> (8 * off);
        case (f3)
            3'b000:  return {{24{s[7]}}, s[7:0]};
            3'b100:  return {24'b0, s[7:0]};
            3'b001:  return {{16{s[15]}}, s[15:0]};
            3'b101:  return {16'b0, s[15:0]};
            default: return word;
        endcase
    endfunction

    function automatic bit branchRef(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic stopOnError();
        $display("** FAIL **");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic checkWord(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            stopOnError();
        end
    endtask

    task automatic checkMask(input string name, input logic [3:0] expected,
                             input logic [3:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %b, actual %b", name, expected, actual);
            stopOnError();
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %b, actual %b", name, expected, actual);
            stopOnError();
        end
    endtask

    task automatic beginProgram();
        @(posedge clk);
        reset <= 1'b1;
        for (int k = 0; k < 256; k++) begin
            imem[k] = nopWord;
        end
        progLen = 0;
        trace.delete();
        storeData.delete();
        storeAddr.delete();
        storeMask.delete();
        illegalAt.delete();
    endtask

    task automatic emit(input logic [31:0] word, input bit runs = 1'b1);
        if (runs) begin
            trace.push_back(progLen * 4);
        end
        imem[progLen] = word;
        progLen++;
    endtask

    // lui plus addi with the upper part rounded for the signed low part
    task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;
        emit({upper[31:12], rd, 7'b0110111});
        emit(encI(value[11:0], rd, 3'b000, rd, rvPkg::opImm));
    endtask

    task automatic emitStore(input logic [4:0] rs2, input logic [11:0] off,
                             input logic [2:0] f3, input logic [31:0] regValue);
        logic [3:0] width;
        width = (f3 == 3'b000) ? 4'b0001 : (f3 == 3'b001) ? 4'b0011 : 4'b1111;
        storeData[progLen * 4] = regValue << (8 * off[1:0]);
        // base register is x0
        storeAddr[progLen * 4] = {{20{off[11]}}, off};
        storeMask[progLen * 4] = width << off[1:0];
        emit(encS(off, rs2, 5'd0, f3));
    endtask

    task automatic runProgram(input string name);
        int waitCount;
        int p;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        waitCount = 0;
        @(negedge clk);
        while (reset || pc !== 32'd0) begin
            if (waitCount == 20) begin
                $display("%s: timeout, the core did not start at pc 0 after reset", name);
                stopOnError();
            end
            waitCount++;
            @(negedge clk);
        end
        // one instruction per cycle
        for (int k = 0; k < trace.size(); k++) begin
            p = trace[k];
            checkWord({name, " pc"}, p, pc);
            checkFlag({name, " except"}, illegalAt.exists(p) != 0, except);
            checkFlag({name, " memWr"}, storeData.exists(p) != 0, memWr);
            if (storeData.exists(p)) begin
                checkWord({name, " store address"}, storeAddr[p], memAddr);
                checkWord({name, " store data"}, storeData[p], memWriteData);
                checkMask({name, " store mask"}, storeMask[p], wrMask);
            end
            @(negedge clk);
        end
    endtask

    task automatic testAlu();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [11:0] imm;
        beginProgram();
        for (int round = 0; round < 3; round++) begin
            a = randBits(32);
            b = randBits(32);
            loadConst(5'd1, a);
            loadConst(5'd2, b);
            for (int f = 0; f < 8; f++) begin
                for (int alt = 0; alt < 2; alt++) begin
                    if (alt == 1 && f != 0 && f != 5) begin
                        continue;
                    end
                    emit(encR(alt[0] ? 7'b0100000 : 7'b0000000, 5'd2, 5'd1, 3'(f), 5'd3,
                              rvPkg::opReg));
                    emitStore(5'd3, 12'd0, 3'b010, aluRef(3'(f), alt[0], a, b));
                    // no subtract immediate
                    if (alt == 1 && f == 0) begin
                        continue;
                    end
                    r = randBits(12);
                    imm = r[11:0];
                    if (f == 1 || f == 5) begin
                        imm = {alt[0] ? 7'b0100000 : 7'b0000000, r[4:0]};
                    end
                    emit(encI(imm, 5'd1, 3'(f), 5'd3, rvPkg::opImm));
                    emitStore(5'd3, 12'd0, 3'b010,
                              aluRef(3'(f), alt[0], a, {{20{imm[11]}}, imm}));
                end
            end
        end
        runProgram("alu");
    endtask

    task automatic testStoreLanes();
        logic [31:0] v;
        beginProgram();
        v = randBits(32);
        loadConst(5'd1, v);
        for (int o = 0; o < 4; o++) begin
            emitStore(5'd1, 12'(o), 3'b000, v);
            emitStore(5'd1, 12'(o), 3'b001, v);
        end
        emitStore(5'd1, 12'd0, 3'b010, v);
        runProgram("store lanes");
    endtask

    task automatic testLoads();
        logic [31:0] k;
        beginProgram();
        k = randBits(32);
        loadConst(5'd1, k);
        // known word at address 0x40
        emitStore(5'd1, 12'h040, 3'b010, k);
        for (int o = 0; o < 4; o++) begin
            for (int f = 0; f < 6; f++) begin
                if (f == 3 || ((f == 1 || f == 5) && o[0]) || (f == 2 && o != 0)) begin
                    continue;
                end
                emit(encI(12'(64 + o), 5'd0, 3'(f), 5'd4, rvPkg::opLoad));
                emitStore(5'd4, 12'd0, 3'b010, loadRef(k, o, 3'(f)));
            end
        end
        runProgram("loads");
    endtask

    task automatic testControlFlow();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v1;
        logic [31:0] v2;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        bit          taken;
        int          q;
        beginProgram();
        a = randBits(32);
        b = randBits(32);
        // opposite signs so signed and unsigned order differ
        b[31] = ~a[31];
        loadConst(5'd1, a);
        loadConst(5'd2, b);
        loadConst(5'd3, a);
        for (int c = 0; c < 6; c++) begin
            f3 = (c < 2) ? 3'(c) : 3'(c + 2);
            for (int pr = 0; pr < 3; pr++) begin
                rs1 = (pr == 1) ? 5'd2 : 5'd1;
                rs2 = (pr == 0) ? 5'd2 : (pr == 1) ? 5'd1 : 5'd3;
                v1 = (pr == 1) ? b : a;
                v2 = (pr == 0) ? b : a;
                taken = branchRef(f3, v1, v2);
                emit(encB(13'd8, rs2, rs1, f3));
                emit(encI(12'd1, 5'd0, 3'b000, 5'd5, rvPkg::opImm), !taken);
            end
        end
        q = progLen * 4;
        emit(encJ(21'd8, 5'd7));
        emit(nopWord, 1'b0);
        emitStore(5'd7, 12'd0, 3'b010, q + 4);
        // odd target whose bit 0 is dropped
        q = (progLen + 2) * 4;
        loadConst(5'd8, q + 9);
        emit(encI(12'd0, 5'd8, 3'b000, 5'd7, rvPkg::opJalr));
        emit(nopWord, 1'b0);
        emitStore(5'd7, 12'd0, 3'b010, q + 4);
        runProgram("control flow");
    endtask

    task automatic testUpperImm();
        logic [31:0] r;
        int          q;
        beginProgram();
        for (int round = 0; round < 3; round++) begin
            r = randBits(20);
            emit({r[19:0], 5'd10, 7'b0110111});
            emitStore(5'd10, 12'd0, 3'b010, {r[19:0], 12'b0});
            q = progLen * 4;
            emit({r[19:0], 5'd11, 7'b0010111});
            emitStore(5'd11, 12'd0, 3'b010, q + {r[19:0], 12'b0});
        end
        runProgram("upper immediates");
    endtask

    task automatic testIllegal();
        logic [31:0] v;
        logic [31:0] bad [5];
        bad[0] = encI(12'h005, 5'd1, 3'b000, 5'd9, 7'b0001011);
        bad[1] = encR(7'b0000001, 5'd2, 5'd1, 3'b000, 5'd9, rvPkg::opReg);
        bad[2] = encI(12'h000, 5'd0, 3'b000, 5'd9, 7'b1110011);
        bad[3] = encB(13'd8, 5'd2, 5'd1, 3'b010);
        // store with an unsupported width
        bad[4] = encS(12'h000, 5'd9, 5'd0, 3'b011);
        beginProgram();
        v = randBits(32);
        loadConst(5'd9, v);
        for (int k = 0; k < 5; k++) begin
            illegalAt[progLen * 4] = 1'b1;
            emit(bad[k]);
            emitStore(5'd9, 12'd0, 3'b010, v);
        end
        runProgram("illegal");
    endtask

    initial begin
        reset = 1'b1;
        lfsrState = 32'h636a;
        progLen = 0;
        for (int k = 0; k < 256; k++) begin
            imem[k] = nopWord;
        end
        testAlu();
        testStoreLanes();
        testLoads();
        testControlFlow();
        testUpperImm();
        testIllegal();
        @(negedge clk);
        if (i_cpu.cpuChecks.failCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: tb.f
hdl/rvPkg.sv
hdl/controller.sv
hdl/immDecoder.sv
hdl/alu.sv
hdl/registerFile.sv
hdl/loadStoreUnit.sv
hdl/cpu.sv
bench/cpuTb_assert.sv
bench/cpuTb.sv

// File: run.sh
#!/bin/sh
rm -f sim.log &&
verilator --binary --timing --assert --top-module cpuTb -f tb.f -o simv &&
./obj_dir/simv +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx '\*\* PASS \*\*' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
